// ==== logic/arcade_macros.svh ====
//==================================================
// Build-time sizing for the arcade shell
// Player count above two adds mappers only, the
// key table and start bits cover two players
//==================================================
`ifndef ARCADE_MACROS_SVH
`define ARCADE_MACROS_SVH

// Players, one mapper each
`define ARC_NUM_PLAYERS 2

// DAC input and accumulator width, multiple of 8
`define ARC_DAC_BITS 16

// System clocks per pixel
`define ARC_CE_DIV 4

`endif

// ==== logic/arcade_input_pkg.sv ====
//==================================================
// Input side types: PS/2 set-2 codes, key channel
// word and the per-player control bundle
//==================================================
`default_nettype none

package arcade_input_pkg;

	// Set-2 make codes, extended prefix already stripped
	typedef enum logic [7:0] {
		KEY_F1    = 8'h05,
		KEY_F2    = 8'h06,
		KEY_LCTRL = 8'h14,
		KEY_S     = 8'h1B,
		KEY_A     = 8'h1C,
		KEY_W     = 8'h1D,
		KEY_D     = 8'h23,
		KEY_SPACE = 8'h29,
		KEY_5     = 8'h2E,
		KEY_LEFT  = 8'h6B,
		KEY_DOWN  = 8'h72,
		KEY_RIGHT = 8'h74,
		KEY_UP    = 8'h75,
		KEY_ESC   = 8'h76
	} key_code_e;

	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire;
		logic coin;
		logic start;
	} player_ctrl_t;

	// As delivered by the board's key channel
	typedef struct packed {
		logic       toggle; // Flips once per event
		logic       pressed;
		logic [7:0] code;
	} key_event_t;

endpackage

`default_nettype wire

// ==== logic/arcade_av_pkg.sv ====
//==================================================
// Video types: core colour, VGA colour and the
// scanline dimming level
//==================================================
`default_nettype none

package arcade_av_pkg;

	// Core colour, 3-3-2
	typedef struct packed {
		logic [2:0] r;
		logic [2:0] g;
		logic [1:0] b;
	} core_pixel_t;

	typedef struct packed {
		logic [5:0] r;
		logic [5:0] g;
		logic [5:0] b;
	} vga_pixel_t;

	// Amount of darkening applied to odd lines
	typedef enum logic [1:0] {
		SL_OFF   = 2'd0,
		SL_PCT25 = 2'd1,
		SL_PCT50 = 2'd2,
		SL_PCT75 = 2'd3
	} scanline_e;

endpackage

`default_nettype wire

// ==== logic/ps2_key_decoder.sv ====
//==================================================
// Key events must be at least one cycle apart
// Unknown codes leave all key states untouched
//==================================================
`timescale 1ns/1ps
`default_nettype none

`include "arcade_macros.svh"

module ps2_key_decoder (
	input  wire logic                           clk_sys,
	input  wire logic                           rst_n,
	input  arcade_input_pkg::key_event_t        key_event,
	output arcade_input_pkg::player_ctrl_t      player_keys [0:`ARC_NUM_PLAYERS-1]
);

	localparam int PIDX_W = (`ARC_NUM_PLAYERS > 1) ? $clog2(`ARC_NUM_PLAYERS) : 1;

	arcade_input_pkg::key_event_t   evt_q;       // Edge register stage
	logic                           toggle_prev;
	logic                           new_evt;
	logic [PIDX_W-1:0]              hit_player;
	arcade_input_pkg::player_ctrl_t hit_mask;

	assign new_evt = evt_q.toggle != toggle_prev;

	// Which control bit the code drives
	always_comb begin
		hit_mask = '0;
		case (arcade_input_pkg::key_code_e'(evt_q.code))
			arcade_input_pkg::KEY_UP,    arcade_input_pkg::KEY_W:     hit_mask = '{up: 1'b1, default: 1'b0};
			arcade_input_pkg::KEY_DOWN,  arcade_input_pkg::KEY_S:     hit_mask = '{down: 1'b1, default: 1'b0};
			arcade_input_pkg::KEY_LEFT,  arcade_input_pkg::KEY_A:     hit_mask = '{left: 1'b1, default: 1'b0};
			arcade_input_pkg::KEY_RIGHT, arcade_input_pkg::KEY_D:     hit_mask = '{right: 1'b1, default: 1'b0};
			arcade_input_pkg::KEY_SPACE, arcade_input_pkg::KEY_LCTRL: hit_mask = '{fire: 1'b1, default: 1'b0};
			arcade_input_pkg::KEY_ESC,   arcade_input_pkg::KEY_5:     hit_mask = '{coin: 1'b1, default: 1'b0};
			arcade_input_pkg::KEY_F1,    arcade_input_pkg::KEY_F2:    hit_mask = '{start: 1'b1, default: 1'b0};
			default: hit_mask = '0; // Not ours
		endcase
	end

	// Owning player, second key group belongs to player 1
	always_comb begin
		case (arcade_input_pkg::key_code_e'(evt_q.code))
			arcade_input_pkg::KEY_W, arcade_input_pkg::KEY_S,
			arcade_input_pkg::KEY_A, arcade_input_pkg::KEY_D,
			arcade_input_pkg::KEY_LCTRL, arcade_input_pkg::KEY_5,
			arcade_input_pkg::KEY_F2: hit_player = PIDX_W'(1);
			default:                  hit_player = '0;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			evt_q       <= '0;
			toggle_prev <= 1'b0;
			for (int p = 0; p < `ARC_NUM_PLAYERS; p++) begin
				player_keys[p] <= '0;
			end
		end else begin
			evt_q       <= key_event;
			toggle_prev <= evt_q.toggle;
			for (int p = 0; p < `ARC_NUM_PLAYERS; p++) begin
				if (new_evt && hit_player == PIDX_W'(p)) begin
					if (evt_q.pressed)
						player_keys[p] <= player_keys[p] | hit_mask;
					else
						player_keys[p] <= player_keys[p] & ~hit_mask; // Release
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/player_control_mapper.sv ====
//==================================================
// Joystick bits: right 0, left 1, down 2, up 3,
// fire 4; upper bits are not used by this core
//==================================================
`timescale 1ns/1ps
`default_nettype none

module player_control_mapper (
	input  wire logic                      clk_sys,
	input  wire logic                      rst_n,
	input  arcade_input_pkg::player_ctrl_t keys,
	input  wire logic [7:0]                joystick,
	input  wire logic                      rotate,
	output arcade_input_pkg::player_ctrl_t controls
);

	arcade_input_pkg::player_ctrl_t merged;
	arcade_input_pkg::player_ctrl_t rotated;

	always_comb begin
		merged       = keys; // Coin and start come from keys only
		merged.right = keys.right | joystick[0];
		merged.left  = keys.left  | joystick[1];
		merged.down  = keys.down  | joystick[2];
		merged.up    = keys.up    | joystick[3];
		merged.fire  = keys.fire  | joystick[4];

		// Quarter turn for a sideways mounted monitor
		rotated = merged;
		if (rotate) begin
			rotated.up    = merged.left;
			rotated.down  = merged.right;
			rotated.left  = merged.down;
			rotated.right = merged.up;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n)
			controls <= '0;
		else
			controls <= rotated;
	end

endmodule

`default_nettype wire

// ==== logic/cabinet_input_packer.sv ====
//==================================================
// Directions, fire and coin are shared by all
// players; starts from player 1 up go to start-two
//==================================================
`timescale 1ns/1ps
`default_nettype none

`include "arcade_macros.svh"

module cabinet_input_packer (
	input  wire logic                      clk_sys,
	input  wire logic                      rst_n,
	input  arcade_input_pkg::player_ctrl_t controls [0:`ARC_NUM_PLAYERS-1],
	output logic [7:0]                     in0,
	output logic [7:0]                     in1
);

	arcade_input_pkg::player_ctrl_t any_ctrl;
	logic start_one;
	logic start_two;

	always_comb begin
		any_ctrl  = '0;
		start_one = 1'b0;
		start_two = 1'b0;
		for (int p = 0; p < `ARC_NUM_PLAYERS; p++) begin
			any_ctrl = any_ctrl | controls[p];
			if (p == 0)
				start_one = controls[p].start;
			else
				start_two = start_two | controls[p].start;
		end
	end

	// Core registers are active low
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			in0 <= 8'hFF;
			in1 <= 8'hFF;
		end else begin
			in0 <= ~{2'b00, any_ctrl.coin, 1'b0, any_ctrl.down, any_ctrl.right,
				any_ctrl.left, any_ctrl.up};
			in1 <= ~{1'b0, start_two, start_one, any_ctrl.fire, 4'b0000};
		end
	end

endmodule

`default_nettype wire

// ==== logic/video_output_stage.sv ====
//==================================================
// Inputs are sampled on ce_pix cycles only
// Line parity flips on rising hsync seen at ce_pix
//==================================================
`timescale 1ns/1ps
`default_nettype none

`include "arcade_macros.svh"

module video_output_stage (
	input  wire logic                  clk_sys,
	input  wire logic                  rst_n,
	input  arcade_av_pkg::core_pixel_t pixel,
	input  wire logic                  hsync,
	input  wire logic                  vsync,
	input  wire logic                  hblank,
	input  wire logic                  vblank,
	input  arcade_av_pkg::scanline_e   scanlines,
	output logic                       ce_pix,
	output arcade_av_pkg::vga_pixel_t  vga,
	output logic                       vga_hs,
	output logic                       vga_vs
);

	localparam int CNT_W = (`ARC_CE_DIV > 1) ? $clog2(`ARC_CE_DIV) : 1;

	logic [CNT_W-1:0]          div_cnt;
	logic                      line_odd;
	arcade_av_pkg::vga_pixel_t wide;
	arcade_av_pkg::vga_pixel_t shaded;

	// Brightness after dimming, truncated
	function automatic logic [5:0] dim(input logic [5:0] c, input arcade_av_pkg::scanline_e lvl);
		logic [5:0] res;
		case (lvl)
			arcade_av_pkg::SL_PCT25: res = (c >> 1) + (c >> 2); // 75%
			arcade_av_pkg::SL_PCT50: res = c >> 1;
			arcade_av_pkg::SL_PCT75: res = c >> 2;
			default:                 res = c;
		endcase
		return res;
	endfunction

	always_comb begin
		wide.r = {pixel.r, pixel.r};
		wide.g = {pixel.g, pixel.g};
		wide.b = {pixel.b, pixel.b, pixel.b};
		if (hblank | vblank)
			wide = '0;
		shaded = wide;
		if (line_odd) begin
			shaded.r = dim(wide.r, scanlines);
			shaded.g = dim(wide.g, scanlines);
			shaded.b = dim(wide.b, scanlines);
		end
	end

	//==================================================
	// Pixel clock enable
	//==================================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			div_cnt <= '0;
			ce_pix  <= 1'b0;
		end else begin
			ce_pix  <= div_cnt == CNT_W'(`ARC_CE_DIV - 1);
			div_cnt <= (div_cnt == CNT_W'(`ARC_CE_DIV - 1)) ? '0 : div_cnt + 1'b1;
		end
	end

	//==================================================
	// Output registers
	//==================================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			vga      <= '0;
			vga_hs   <= 1'b0;
			vga_vs   <= 1'b0;
			line_odd <= 1'b0;
		end else if (ce_pix) begin
			vga    <= shaded;
			vga_hs <= hsync;
			vga_vs <= vsync;
			if (vsync)
				line_odd <= 1'b0;
			else if (hsync && !vga_hs) // vga_hs holds last sampled hsync
				line_odd <= ~line_odd;
		end
	end

endmodule

`default_nettype wire

// ==== logic/sigma_delta_dac.sv ====
//==================================================
// First order, unsigned input, full scale gives
// a duty cycle just under one
//==================================================
`timescale 1ns/1ps
`default_nettype none

`include "arcade_macros.svh"

module sigma_delta_dac (
	input  wire logic                     clk_sys,
	input  wire logic                     rst_n,
	input  wire logic [`ARC_DAC_BITS-1:0] sample,
	output logic                          dac_out
);

	logic [`ARC_DAC_BITS-1:0] acc;
	logic [`ARC_DAC_BITS:0]   sum;

	assign sum = {1'b0, acc} + {1'b0, sample}; // Top bit is the carry

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			acc     <= '0;
			dac_out <= 1'b0;
		end else begin
			acc     <= sum[`ARC_DAC_BITS-1:0];
			dac_out <= sum[`ARC_DAC_BITS];
		end
	end

endmodule

`default_nettype wire

// ==== logic/arcade_shell.sv ====
//==================================================
// Core, PLL, config link and scan doubler live
// outside; options arrive as static levels
//==================================================
`timescale 1ns/1ps
`default_nettype none

`include "arcade_macros.svh"

module arcade_shell (
	input  wire logic                  clk_sys,
	input  wire logic                  rst_n,
	input  arcade_input_pkg::key_event_t key_event,
	input  wire logic [7:0]            joystick [0:`ARC_NUM_PLAYERS-1],
	input  wire logic                  rotate,
	input  arcade_av_pkg::scanline_e   scanlines,
	input  arcade_av_pkg::core_pixel_t core_pixel,
	input  wire logic                  core_hsync,
	input  wire logic                  core_vsync,
	input  wire logic                  core_hblank,
	input  wire logic                  core_vblank,
	input  wire logic [7:0]            core_audio,
	output logic                       ce_pix,
	output logic [7:0]                 in0,
	output logic [7:0]                 in1,
	output arcade_av_pkg::vga_pixel_t  vga,
	output logic                       vga_hs,
	output logic                       vga_vs,
	output logic                       audio_out
);

	arcade_input_pkg::player_ctrl_t player_keys  [0:`ARC_NUM_PLAYERS-1];
	arcade_input_pkg::player_ctrl_t player_ctrls [0:`ARC_NUM_PLAYERS-1];
	logic [`ARC_DAC_BITS-1:0]       dac_sample;

	//==================================================
	// Control path
	//==================================================
	ps2_key_decoder i_key_decoder (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.key_event   (key_event),
		.player_keys (player_keys)
	);

	for (genvar p = 0; p < `ARC_NUM_PLAYERS; p++) begin : g_player
		player_control_mapper i_mapper (
			.clk_sys  (clk_sys),
			.rst_n    (rst_n),
			.keys     (player_keys[p]),
			.joystick (joystick[p]),
			.rotate   (rotate),
			.controls (player_ctrls[p])
		);
	end

	cabinet_input_packer i_packer (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.controls (player_ctrls),
		.in0      (in0),
		.in1      (in1)
	);

	//==================================================
	// Video and sound
	//==================================================
	video_output_stage i_video (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.pixel     (core_pixel),
		.hsync     (core_hsync),
		.vsync     (core_vsync),
		.hblank    (core_hblank),
		.vblank    (core_vblank),
		.scanlines (scanlines),
		.ce_pix    (ce_pix),
		.vga       (vga),
		.vga_hs    (vga_hs),
		.vga_vs    (vga_vs)
	);

	assign dac_sample = {(`ARC_DAC_BITS / 8){core_audio}}; // Repeat to fill full scale

	sigma_delta_dac i_dac (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.sample  (dac_sample),
		.dac_out (audio_out)
	);

endmodule

`default_nettype wire

// ==== test/arcade_shell_checker.sv ====
//==================================================
// Bound into the video stage and the DAC
// Unused ports of a binding are tied low
//==================================================
`timescale 1ns/1ps
`default_nettype none

`include "arcade_macros.svh"

module arcade_shell_checker (
	input wire logic        clk_sys,
	input wire logic        rst_n,
	input wire logic        ce_pix,
	input wire logic [17:0] vga,
	input wire logic        dac_out
);

	// Reset clears every output on the next cycle
	a_reset_clears: assert property (@(posedge clk_sys)
		!rst_n |=> (!ce_pix && vga == 18'd0 && !dac_out))
		else $error("Outputs not cleared after reset");

	a_ce_single: assert property (@(posedge clk_sys) disable iff (!rst_n)
		ce_pix |=> !ce_pix)
		else $error("Pixel enable held longer than one cycle");

	a_ce_period: assert property (@(posedge clk_sys) disable iff (!rst_n)
		ce_pix |-> ##`ARC_CE_DIV ce_pix)
		else $error("Pixel enable period broken");

endmodule

bind video_output_stage arcade_shell_checker i_video_chk (
	.clk_sys (clk_sys),
	.rst_n   (rst_n),
	.ce_pix  (ce_pix),
	.vga     (vga),
	.dac_out (1'b0)
);

bind sigma_delta_dac arcade_shell_checker i_dac_chk (
	.clk_sys (clk_sys),
	.rst_n   (rst_n),
	.ce_pix  (1'b0),
	.vga     (18'd0),
	.dac_out (dac_out)
);

`default_nettype wire

// ==== test/arcade_shell_tb.sv ====
//==================================================
// Cycle model of the shell compares every output
// after each edge
// Key table covers two players only
//==================================================
`timescale 1ns/1ps
`default_nettype none

`include "arcade_macros.svh"

module arcade_shell_tb;

	localparam int UP = 0, DOWN = 1, LEFT = 2, RIGHT = 3, FIRE = 4, COIN = 5, START = 6;
	localparam int NP = `ARC_NUM_PLAYERS;
	localparam int DB = `ARC_DAC_BITS;

	logic                           clk_sys;
	logic                           rst_n;
	arcade_input_pkg::key_event_t   key_event;
	logic [7:0]                     joystick [0:NP-1];
	logic                           rotate;
	arcade_av_pkg::scanline_e       scanlines;
	arcade_av_pkg::core_pixel_t     core_pixel;
	logic core_hsync, core_vsync, core_hblank, core_vblank;
	logic [7:0]                     core_audio;
	logic                           ce_pix;
	logic [7:0]                     in0, in1;
	arcade_av_pkg::vga_pixel_t      vga;
	logic vga_hs, vga_vs, audio_out;

	// Values applied at the next edge
	logic       nxt_rst_n, nxt_rotate, nxt_hs, nxt_vs, nxt_hb, nxt_vb;
	logic [9:0] nxt_evt;
	logic [7:0] nxt_joy [0:NP-1];
	logic [1:0] nxt_sl;
	logic [7:0] nxt_pix, nxt_audio;

	//==================================================
	// Model state
	//==================================================
	logic [9:0]    m_evt;
	logic          m_tog_prev;
	logic [6:0]    m_keys [0:NP-1];
	logic [6:0]    m_ctrl [0:NP-1];
	logic [7:0]    m_in0, m_in1;
	int            m_cnt;
	logic          m_ce, m_hs, m_vs, m_odd, m_aout;
	logic [17:0]   m_vga;
	logic [DB-1:0] m_acc;

	logic [7:0] key_codes [0:13] = '{8'h75, 8'h72, 8'h6B, 8'h74, 8'h29, 8'h76, 8'h05,
		8'h1D, 8'h1B, 8'h1C, 8'h23, 8'h14, 8'h2E, 8'h06};

	arcade_shell i_arcade_shell (
		.clk_sys (clk_sys), .rst_n (rst_n), .key_event (key_event),
		.joystick (joystick), .rotate (rotate), .scanlines (scanlines),
		.core_pixel (core_pixel), .core_hsync (core_hsync), .core_vsync (core_vsync),
		.core_hblank (core_hblank), .core_vblank (core_vblank),
		.core_audio (core_audio), .ce_pix (ce_pix), .in0 (in0), .in1 (in1),
		.vga (vga), .vga_hs (vga_hs), .vga_vs (vga_vs), .audio_out (audio_out)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// {valid, player, control bit} for a set-2 code
	function automatic logic [4:0] key_target(input logic [7:0] code);
		case (code)
			8'h75: return {2'b10, 3'(UP)};
			8'h72: return {2'b10, 3'(DOWN)};
			8'h6B: return {2'b10, 3'(LEFT)};
			8'h74: return {2'b10, 3'(RIGHT)};
			8'h29: return {2'b10, 3'(FIRE)};
			8'h76: return {2'b10, 3'(COIN)};
			8'h05: return {2'b10, 3'(START)};
			8'h1D: return {2'b11, 3'(UP)};
			8'h1B: return {2'b11, 3'(DOWN)};
			8'h1C: return {2'b11, 3'(LEFT)};
			8'h23: return {2'b11, 3'(RIGHT)};
			8'h14: return {2'b11, 3'(FIRE)};
			8'h2E: return {2'b11, 3'(COIN)};
			8'h06: return {2'b11, 3'(START)};
			default: return 5'b0;
		endcase
	endfunction

	function automatic logic [6:0] map_ctrl(input logic [6:0] k, input logic [7:0] j,
		input logic rot);
		logic [6:0] m;
		logic [6:0] r;
		m = k;
		m[RIGHT] = k[RIGHT] | j[0];
		m[LEFT]  = k[LEFT] | j[1];
		m[DOWN]  = k[DOWN] | j[2];
		m[UP]    = k[UP] | j[3];
		m[FIRE]  = k[FIRE] | j[4];
		r = m;
		if (rot) begin
			r[UP]    = m[LEFT];
			r[DOWN]  = m[RIGHT];
			r[LEFT]  = m[DOWN];
			r[RIGHT] = m[UP];
		end
		return r;
	endfunction

	function automatic logic [5:0] dim_chan(input logic [5:0] c, input logic [1:0] lvl);
		case (lvl)
			2'd1: return (c >> 1) + (c >> 2); // 75% left
			2'd2: return c >> 1;
			2'd3: return c >> 2;
			default: return c;
		endcase
	endfunction

	function automatic logic [17:0] shade(input logic [7:0] p, input logic blank,
		input logic odd, input logic [1:0] lvl);
		logic [5:0] r, g, b;
		r = blank ? 6'd0 : {p[7:5], p[7:5]};
		g = blank ? 6'd0 : {p[4:2], p[4:2]};
		b = blank ? 6'd0 : {p[1:0], p[1:0], p[1:0]};
		if (odd)
			return {dim_chan(r, lvl), dim_chan(g, lvl), dim_chan(b, lvl)};
		return {r, g, b};
	endfunction

	task automatic stop_on_error;
		$display("Testbench failed");
		$fatal(1, "Run stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [17:0] got,
		input logic [17:0] exp);
		assert (got === exp) else begin
			$display("FAILED time=%0t %s got=%0h expected=%0h", $time, name, got, exp);
			stop_on_error();
		end
	endtask

	// Advance the model with the inputs the DUT samples at this edge
	task automatic model_update;
		logic [6:0]    any;
		logic          s1, s2;
		logic [4:0]    tgt;
		logic [DB:0]   sum;
		if (!rst_n) begin
			m_in0 = 8'hFF;
			m_in1 = 8'hFF;
			for (int p = 0; p < NP; p++) begin
				m_keys[p] = '0;
				m_ctrl[p] = '0;
			end
			m_evt = '0;
			m_tog_prev = 1'b0;
			m_cnt = 0;
			{m_ce, m_hs, m_vs, m_odd, m_aout} = '0;
			m_vga = '0;
			m_acc = '0;
		end else begin
			any = '0;
			s1  = 1'b0;
			s2  = 1'b0;
			for (int p = 0; p < NP; p++) begin
				any = any | m_ctrl[p];
				if (p == 0) s1 = m_ctrl[p][START];
				else        s2 = s2 | m_ctrl[p][START];
			end
			m_in0 = ~{2'b00, any[COIN], 1'b0, any[DOWN], any[RIGHT], any[LEFT], any[UP]};
			m_in1 = ~{1'b0, s2, s1, any[FIRE], 4'b0000};
			for (int p = 0; p < NP; p++)
				m_ctrl[p] = map_ctrl(m_keys[p], joystick[p], rotate);
			if (m_evt[9] != m_tog_prev) begin
				tgt = key_target(m_evt[7:0]);
				if (tgt[4])
					m_keys[tgt[3]][tgt[2:0]] = m_evt[8];
			end
			m_tog_prev = m_evt[9];
			m_evt      = key_event;

			if (m_ce) begin
				m_vga = shade(core_pixel, core_hblank | core_vblank, m_odd, scanlines);
				if (core_vsync)
					m_odd = 1'b0;
				else if (core_hsync && !m_hs)
					m_odd = ~m_odd; // Rising hsync
				m_hs = core_hsync;
				m_vs = core_vsync;
			end
			m_ce  = (m_cnt % `ARC_CE_DIV) == (`ARC_CE_DIV - 1);
			m_cnt = m_cnt + 1;

			sum    = {1'b0, m_acc} + {1'b0, {(DB / 8){core_audio}}};
			m_aout = sum[DB];
			m_acc  = sum[DB-1:0];
		end
	endtask

	task automatic step;
		@(posedge clk_sys);
		model_update();
		rst_n      <= nxt_rst_n;
		key_event  <= nxt_evt;
		for (int p = 0; p < NP; p++)
			joystick[p] <= nxt_joy[p];
		rotate      <= nxt_rotate;
		scanlines   <= arcade_av_pkg::scanline_e'(nxt_sl);
		core_pixel  <= nxt_pix;
		core_hsync  <= nxt_hs;
		core_vsync  <= nxt_vs;
		core_hblank <= nxt_hb;
		core_vblank <= nxt_vb;
		core_audio  <= nxt_audio;
		#1;
		check_value("in0", 18'(in0), 18'(m_in0));
		check_value("in1", 18'(in1), 18'(m_in1));
		check_value("ce_pix", 18'(ce_pix), 18'(m_ce));
		check_value("vga", 18'(vga), m_vga);
		check_value("vga_hs", 18'(vga_hs), 18'(m_hs));
		check_value("vga_vs", 18'(vga_vs), 18'(m_vs));
		check_value("audio_out", 18'(audio_out), 18'(m_aout));
	endtask

	task automatic wait_for_ce;
		int n;
		n = 0;
		while (!ce_pix) begin
			if (n >= 4 * `ARC_CE_DIV) begin
				$display("Timeout waiting for the pixel clock enable");
				stop_on_error();
			end
			step();
			n++;
		end
	endtask

	initial begin
		void'($urandom(32'h8c06));
		rst_n = 1'b0;
		key_event = '0;
		rotate = 1'b0;
		scanlines = arcade_av_pkg::SL_OFF;
		core_pixel = '0;
		{core_hsync, core_vsync, core_hblank, core_vblank} = '0;
		core_audio = '0;
		{nxt_rst_n, nxt_rotate, nxt_hs, nxt_vs, nxt_hb, nxt_vb} = '0;
		nxt_evt = '0;
		nxt_sl = '0;
		nxt_pix = '0;
		nxt_audio = '0;
		for (int p = 0; p < NP; p++) begin
			joystick[p] = '0;
			nxt_joy[p]  = '0;
		end

		// Reset seen low at four clock edges
		repeat (3) step();
		nxt_rst_n = 1'b1;
		step();

		// Key events including unknown codes
		for (int i = 0; i < 200; i++) begin
			nxt_evt[7:0] = ($urandom % 5 == 0) ? 8'($urandom) : key_codes[4'($urandom % 14)];
			nxt_evt[8]   = 1'($urandom);
			nxt_evt[9]   = ~nxt_evt[9];
			step();
			repeat ($urandom_range(1, 4)) step();
		end

		// Joystick and rotation
		for (int i = 0; i < 100; i++) begin
			for (int p = 0; p < NP; p++)
				nxt_joy[p] = 8'($urandom);
			nxt_rotate = 1'($urandom);
			repeat (2 + $urandom % 2) step();
		end

		//==================================================
		// Video with one set of inputs per pixel
		//==================================================
		wait_for_ce();
		for (int i = 0; i < 300; i++) begin
			nxt_pix = 8'($urandom);
			nxt_hb  = ($urandom % 8) == 0;
			nxt_vb  = ($urandom % 16) == 0;
			nxt_hs  = ($urandom % 4) == 0;
			nxt_vs  = ($urandom % 40) == 0;
			nxt_sl  = 2'($urandom);
			repeat (`ARC_CE_DIV) step();
		end

		// Audio held for random stretches
		for (int i = 0; i < 60; i++) begin
			nxt_audio = 8'($urandom);
			repeat ($urandom_range(1, 40)) step();
		end

		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+logic
logic/arcade_input_pkg.sv
logic/arcade_av_pkg.sv
logic/ps2_key_decoder.sv
logic/player_control_mapper.sv
logic/cabinet_input_packer.sv
logic/video_output_stage.sv
logic/sigma_delta_dac.sv
logic/arcade_shell.sv
test/arcade_shell_checker.sv
test/arcade_shell_tb.sv

// ==== Makefile ====
# Verilator flow for the arcade shell testbench
VERILATOR ?= verilator
TOP       ?= arcade_shell_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Testbench passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
